// File: common/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// line geometry
`define CONV_LANES          8
`define CONV_LANE_WIDTH     8
`define CONV_LINE_DEPTH     16

// signed sum over up to 16 full lines
`define CONV_ACC_WIDTH      24

// wishbone word address
`define CONV_WB_ADDR_WIDTH  7

// read request to accumulator update
`define CONV_PIPE_DEPTH     3

// register map
`define CONV_REG_CTRL       7'h40
`define CONV_REG_STATUS     7'h41
`define CONV_REG_RESULT     7'h42

`endif

// File: common/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

    // one signed lane
    typedef logic signed [`CONV_LANE_WIDTH-1:0] lane_t;

    // lane 0 sits in the low byte
    typedef lane_t [`CONV_LANES-1:0] feature_line_t;
    typedef lane_t [`CONV_LANES-1:0] weight_line_t;

    typedef logic [$clog2(`CONV_LINE_DEPTH)-1:0] line_addr_t;

    typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

    typedef logic [31:0] wb_word_t;

    // engine sequencing
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        STREAM = 2'd1,
        DRAIN  = 2'd2
    } engine_state_t;

endpackage

// File: hw/line_ram.sv
`include "conv_params.svh"

module line_ram #(
    parameter type line_t = conv_pkg::feature_line_t
) (
    input  logic                 clk_i,
    input  logic                 we_i,
    input  conv_pkg::line_addr_t wr_addr_i,
    input  line_t                wr_data_i,
    input  logic                 rd_en_i,
    input  conv_pkg::line_addr_t rd_addr_i,
    output line_t                rd_data_o
);

    line_t mem_q [`CONV_LINE_DEPTH];

    // host write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // engine read port, one cycle latency
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

// File: hw/wb_conv_regs.sv
`include "conv_params.svh"

module wb_conv_regs (
    input  logic                              clk_i,
    input  logic                              rd_weight_rst,
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [`CONV_WB_ADDR_WIDTH-1:0]    wb_adr_i,
    input  conv_pkg::wb_word_t                wb_dat_i,
    input  logic                              busy_i,
    input  logic                              done_i,
    input  conv_pkg::acc_t                    acc_i,
    output conv_pkg::wb_word_t                wb_dat_o,
    output logic                              wb_ack_o,
    output logic                              feat_we_o,
    output logic                              wgt_we_o,
    output conv_pkg::line_addr_t              wr_addr_o,
    output conv_pkg::feature_line_t           wr_line_o,
    output logic                              start_o,
    output conv_pkg::line_addr_t              base_o,
    output logic [$clog2(`CONV_LINE_DEPTH):0] length_o
);

    localparam int LEN_W = $clog2(`CONV_LINE_DEPTH) + 1;
    localparam int AW    = `CONV_WB_ADDR_WIDTH;

    logic               req;
    logic               stall;
    logic               wr_fire;
    logic               ctrl_fire;
    logic               ctrl_ok;
    logic               sel_feat;
    logic               sel_wgt;
    logic               sel_ctrl;
    logic               sel_status;
    logic               sel_result;
    logic [LEN_W-1:0]   ctrl_len;
    logic [LEN_W:0]     ctrl_end;
    logic               ack_q;
    logic               start_q;
    logic               done_q;
    conv_pkg::line_addr_t base_q;
    logic [LEN_W-1:0]   len_q;
    conv_pkg::wb_word_t stage_q;

    //////////////////////////////////////////////////
    // decode and handshake
    //////////////////////////////////////////////////

    assign sel_feat   = (wb_adr_i[AW-1 -: 2] == 2'b00);
    assign sel_wgt    = (wb_adr_i[AW-1 -: 2] == 2'b01);
    assign sel_ctrl   = (wb_adr_i == `CONV_REG_CTRL);
    assign sel_status = (wb_adr_i == `CONV_REG_STATUS);
    assign sel_result = (wb_adr_i == `CONV_REG_RESULT);

    assign req = wb_cyc_i & wb_stb_i;
    // writes that touch engine inputs wait out a run, from the start pulse on
    assign stall = wb_we_i & (sel_feat | sel_wgt | sel_ctrl) & (busy_i | start_q);

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req & ~ack_q & ~stall;
        end
    end

    assign wb_ack_o  = ack_q & req;
    assign wr_fire   = wb_ack_o & wb_we_i;
    assign ctrl_fire = wr_fire & sel_ctrl;

    //////////////////////////////////////////////////
    // line assembly
    //////////////////////////////////////////////////

    // low half waits here for its partner
    always_ff @(posedge clk_i) begin
        if (wr_fire & (sel_feat | sel_wgt) & ~wb_adr_i[0]) begin
            stage_q <= wb_dat_i;
        end
    end

    assign feat_we_o = wr_fire & sel_feat & wb_adr_i[0];
    assign wgt_we_o  = wr_fire & sel_wgt & wb_adr_i[0];
    assign wr_addr_o = wb_adr_i[4:1];
    assign wr_line_o = {wb_dat_i, stage_q};

    //////////////////////////////////////////////////
    // control and status
    //////////////////////////////////////////////////

    assign ctrl_len = wb_dat_i[8:4];
    assign ctrl_end = {2'b00, wb_dat_i[3:0]} + {1'b0, ctrl_len};
    // zero length or a run past the last line is ignored
    assign ctrl_ok  = (ctrl_len != '0) && (ctrl_end <= (LEN_W + 1)'(`CONV_LINE_DEPTH));

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            start_q <= 1'b0;
            done_q  <= 1'b0;
            base_q  <= '0;
            len_q   <= '0;
        end else begin
            start_q <= ctrl_fire & ctrl_ok;
            if (ctrl_fire & ctrl_ok) begin
                base_q <= wb_dat_i[3:0];
                len_q  <= ctrl_len;
            end
            if (ctrl_fire) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
        end
    end

    assign start_o  = start_q;
    assign base_o   = base_q;
    assign length_o = len_q;

    always_comb begin
        wb_dat_o = '0;
        if (sel_status) begin
            wb_dat_o[0] = busy_i;
            wb_dat_o[1] = done_q;
        end else if (sel_result) begin
            wb_dat_o = {{(32 - `CONV_ACC_WIDTH){acc_i[`CONV_ACC_WIDTH-1]}}, acc_i};
        end
    end

endmodule

// File: conv_engine/op_counter.sv
`include "conv_params.svh"

module op_counter (
    input  logic                              clk_i,
    input  logic                              rd_weight_rst,
    input  logic                              load_i,
    input  conv_pkg::line_addr_t              load_addr_i,
    input  logic [$clog2(`CONV_LINE_DEPTH):0] load_count_i,
    input  logic                              step_i,
    output conv_pkg::line_addr_t              addr_o,
    output logic                              last_o
);

    conv_pkg::line_addr_t                addr_q;
    logic [$clog2(`CONV_LINE_DEPTH):0]   cnt_q;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            addr_q <= '0;
            cnt_q  <= '0;
        end else if (load_i) begin
            addr_q <= load_addr_i;
            cnt_q  <= load_count_i;
        end else begin
            // cycles left, runs free until empty
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            if (step_i) begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    assign addr_o = addr_q;
    assign last_o = (cnt_q == 1);

endmodule

// File: conv_engine/conv_ctrl_fsm.sv
`include "conv_params.svh"

module conv_ctrl_fsm (
    input  logic                              clk_i,
    input  logic                              rd_weight_rst,
    input  logic                              start_i,
    input  conv_pkg::line_addr_t              base_i,
    input  logic [$clog2(`CONV_LINE_DEPTH):0] length_i,
    input  logic                              last_i,
    output logic                              load_o,
    output logic [$clog2(`CONV_LINE_DEPTH):0] load_count_o,
    output conv_pkg::line_addr_t              base_o,
    output logic                              rd_en_o,
    output logic                              valid_o,
    output logic                              clear_o,
    output logic                              busy_o,
    output logic                              done_o
);

    localparam int LEN_W = $clog2(`CONV_LINE_DEPTH) + 1;

    conv_pkg::engine_state_t state_q;
    conv_pkg::engine_state_t state_d;
    logic                    valid_q;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q <= conv_pkg::IDLE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // lines come out of the memories one cycle later
            valid_q <= rd_en_o;
        end
    end

    always_comb begin
        state_d      = state_q;
        load_o       = 1'b0;
        load_count_o = length_i;
        clear_o      = 1'b0;
        done_o       = 1'b0;
        case (state_q)
            conv_pkg::IDLE: begin
                if (start_i) begin
                    load_o  = 1'b1;
                    clear_o = 1'b1;
                    state_d = conv_pkg::STREAM;
                end
            end
            conv_pkg::STREAM: begin
                // same counter then times the pipeline drain
                if (last_i) begin
                    load_o       = 1'b1;
                    load_count_o = LEN_W'(`CONV_PIPE_DEPTH);
                    state_d      = conv_pkg::DRAIN;
                end
            end
            conv_pkg::DRAIN: begin
                if (last_i) begin
                    done_o  = 1'b1;
                    state_d = conv_pkg::IDLE;
                end
            end
            default: begin
                state_d = conv_pkg::IDLE;
            end
        endcase
    end

    assign base_o  = base_i;
    assign rd_en_o = (state_q == conv_pkg::STREAM);
    assign valid_o = valid_q;
    assign busy_o  = (state_q != conv_pkg::IDLE);

endmodule

// File: conv_engine/dot_product.sv
`include "conv_params.svh"

module dot_product (
    input  logic                    clk_i,
    input  logic                    rd_weight_rst,
    input  logic                    clear_i,
    input  logic                    valid_i,
    input  conv_pkg::feature_line_t feature_line_i,
    input  conv_pkg::weight_line_t  weight_line_i,
    output conv_pkg::acc_t          acc_o
);

    localparam int PROD_W = 2 * `CONV_LANE_WIDTH;
    localparam int SUM_W  = PROD_W + $clog2(`CONV_LANES);

    logic signed [PROD_W-1:0] prod_q [`CONV_LANES];
    logic                     valid_q;
    logic signed [SUM_W-1:0]  lane_sum;
    conv_pkg::acc_t           acc_q;

    //////////////////////////////////////////////////
    // stage 1: lane products against weights
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            valid_q <= 1'b0;
            for (int i = 0; i < `CONV_LANES; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                for (int i = 0; i < `CONV_LANES; i++) begin
                    prod_q[i] <= $signed(feature_line_i[i]) * $signed(weight_line_i[i]);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stage 2: lane sum and accumulate
    //////////////////////////////////////////////////

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `CONV_LANES; i++) begin
            lane_sum = lane_sum + prod_q[i];
        end
    end

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            acc_q <= '0;
        end else if (clear_i) begin
            acc_q <= '0;
        end else if (valid_q) begin
            acc_q <= acc_q + lane_sum;
        end
    end

    assign acc_o = acc_q;

endmodule

// File: hw/conv_engine_top.sv
`include "conv_params.svh"

module conv_engine_top (
    input  logic                           clk_i,
    input  logic                           rd_weight_rst,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [`CONV_WB_ADDR_WIDTH-1:0] wb_adr_i,
    input  conv_pkg::wb_word_t             wb_dat_i,
    output conv_pkg::wb_word_t             wb_dat_o,
    output logic                           wb_ack_o
);

    logic                               feat_we;
    logic                               wgt_we;
    conv_pkg::line_addr_t               wr_addr;
    conv_pkg::feature_line_t            wr_line;
    logic                               start;
    conv_pkg::line_addr_t               base;
    logic [$clog2(`CONV_LINE_DEPTH):0]  length;
    logic                               busy;
    logic                               done;
    logic                               load;
    logic [$clog2(`CONV_LINE_DEPTH):0]  load_count;
    conv_pkg::line_addr_t               load_base;
    logic                               last;
    conv_pkg::line_addr_t               rd_addr;
    logic                               rd_en;
    logic                               valid;
    logic                               clear;
    conv_pkg::feature_line_t            feat_line;
    conv_pkg::weight_line_t             wgt_line;
    conv_pkg::acc_t                     acc;

    //////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////

    wb_conv_regs u_regs (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .busy_i        (busy),
        .done_i        (done),
        .acc_i         (acc),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .feat_we_o     (feat_we),
        .wgt_we_o      (wgt_we),
        .wr_addr_o     (wr_addr),
        .wr_line_o     (wr_line),
        .start_o       (start),
        .base_o        (base),
        .length_o      (length)
    );

    line_ram #(
        .line_t (conv_pkg::feature_line_t)
    ) feature_mem (
        .clk_i     (clk_i),
        .we_i      (feat_we),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_line),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (feat_line)
    );

    line_ram #(
        .line_t (conv_pkg::weight_line_t)
    ) weight_mem (
        .clk_i     (clk_i),
        .we_i      (wgt_we),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_line),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (wgt_line)
    );

    //////////////////////////////////////////////////
    // engine
    //////////////////////////////////////////////////

    conv_ctrl_fsm u_fsm (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .start_i       (start),
        .base_i        (base),
        .length_i      (length),
        .last_i        (last),
        .load_o        (load),
        .load_count_o  (load_count),
        .base_o        (load_base),
        .rd_en_o       (rd_en),
        .valid_o       (valid),
        .clear_o       (clear),
        .busy_o        (busy),
        .done_o        (done)
    );

    op_counter u_counter (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .load_i        (load),
        .load_addr_i   (load_base),
        .load_count_i  (load_count),
        .step_i        (rd_en),
        .addr_o        (rd_addr),
        .last_o        (last)
    );

    dot_product u_dot (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .clear_i        (clear),
        .valid_i        (valid),
        .feature_line_i (feat_line),
        .weight_line_i  (wgt_line),
        .acc_o          (acc)
    );

endmodule

// File: dv/conv_props.sv
module conv_props (
    input logic clk_i,
    input logic rd_weight_rst,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic busy_i,
    input logic feat_we_o,
    input logic wgt_we_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // ack only answers a request held since the previous cycle
    ack_follows_req: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i && $past(wb_cyc_i && wb_stb_i)))
        else $error("ack without a held cyc and stb");

    ack_single_cycle: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        wb_ack_o |=> !wb_ack_o)
        else $error("ack held for two cycles");

    // memories are frozen during a run
    no_write_busy: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        (feat_we_o || wgt_we_o) |-> !busy_i)
        else $error("line memory written while engine busy");

endmodule

bind wb_conv_regs conv_props u_props (
    .clk_i         (clk_i),
    .rd_weight_rst (rd_weight_rst),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_ack_o      (wb_ack_o),
    .busy_i        (busy_i),
    .feat_we_o     (feat_we_o),
    .wgt_we_o      (wgt_we_o)
);

// File: dv/conv_checker.sv
`include "conv_params.svh"

module conv_checker (
    input  logic        clk_i,
    input  logic        rd_weight_rst,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [6:0]  wb_adr_i,
    input  logic [31:0] wb_dat_o,
    input  logic        wb_ack_o,
    input  int          test_idx,
    input  logic        final_status,
    input  logic        test_end,
    input  logic        timed_out,
    output int          pass_count,
    output int          fail_count,
    output int          mismatch_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REC_WORDS = 12;
    localparam int NUM_TESTS = 8;

    logic [31:0] pat [NUM_TESTS*REC_WORDS];
    int          test_errors;

    initial begin
        $readmemh("dv/conv_patterns.dat", pat);
        pass_count     = 0;
        fail_count     = 0;
        mismatch_count = 0;
        test_errors    = 0;
    end

    // reset check and ignored control word leave status clear, runs end done
    function automatic logic [31:0] status_expect(input logic [31:0] kind);
        if (kind == 0 || kind == 3) begin
            return 32'h0;
        end
        return 32'h2;
    endfunction

    always @(negedge clk_i) begin
        logic [31:0] exp;
        logic [31:0] kind;
        exp  = '0;
        kind = pat[test_idx*REC_WORDS + 1];
        if (!rd_weight_rst && wb_cyc_i && wb_stb_i && wb_ack_o && !wb_we_i) begin
            if (wb_adr_i == `CONV_REG_RESULT) begin
                exp = pat[test_idx*REC_WORDS + 11];
                if (wb_dat_o !== exp) begin
                    $display("FAIL %0t ns: wb_dat_o (result) expected %h actual %h",
                             $time, exp, wb_dat_o);
                    test_errors++;
                    mismatch_count++;
                end
            end else if (wb_adr_i == `CONV_REG_STATUS && final_status) begin
                exp = status_expect(kind);
                if (wb_dat_o !== exp) begin
                    $display("FAIL %0t ns: wb_dat_o (status) expected %h actual %h",
                             $time, exp, wb_dat_o);
                    test_errors++;
                    mismatch_count++;
                end
            end
        end
        if (test_end) begin
            if (test_errors == 0 && !timed_out) begin
                $display("test %0d kind %0d: ok", test_idx, kind);
                pass_count++;
            end else begin
                $display("test %0d kind %0d: failed, %0d mismatches, timeout %0d",
                         test_idx, kind, test_errors, timed_out);
                fail_count++;
            end
            test_errors = 0;
        end
    end

endmodule

// File: dv/tb_conv_top.sv
`include "conv_params.svh"

module tb_conv_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REC_WORDS = 12;
    localparam int NUM_TESTS = 8;

    logic        clk_i;
    logic        rd_weight_rst;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [6:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    int          test_idx;
    logic        final_status;
    logic        test_end;
    logic        timed_out;
    int          timeouts;
    int          cycle_count;
    int          pass_count;
    int          fail_count;
    int          mismatch_count;
    logic [31:0] pat [NUM_TESTS*REC_WORDS];

    conv_engine_top DUT (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o)
    );

    conv_checker u_checker (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .test_idx       (test_idx),
        .final_status   (final_status),
        .test_end       (test_end),
        .timed_out      (timed_out),
        .pass_count     (pass_count),
        .fail_count     (fail_count),
        .mismatch_count (mismatch_count)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
    end

    //////////////////////////////////////////////////
    // wishbone master
    //////////////////////////////////////////////////

    // one classic cycle, ack looked for at the falling edge
    task automatic bus_cycle(input logic we, input logic [6:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        @(negedge clk_i);
        while (!wb_ack_o && waited < 20) begin
            @(negedge clk_i);
            waited++;
        end
        if (!wb_ack_o) begin
            $display("timeout: no ack within 20 cycles at address %h", adr);
            timeouts++;
            timed_out = 1'b1;
        end
        rdata = wb_dat_o;
        @(posedge clk_i);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic write_word(input logic [6:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_word(input logic [6:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic write_ctrl(input logic [31:0] base, input logic [31:0] len);
        write_word(`CONV_REG_CTRL, {23'b0, len[4:0], base[3:0]});
    endtask

    task automatic wait_done();
        int          start_cycle;
        logic [31:0] st;
        logic        seen;
        start_cycle = cycle_count;
        st          = '0;
        seen        = 1'b0;
        while (!seen && (cycle_count - start_cycle) < 200) begin
            read_word(`CONV_REG_STATUS, st);
            seen = st[1] && !st[0];
        end
        if (!seen) begin
            $display("timeout: engine never reported done within 200 cycles");
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // pattern sequencing
    //////////////////////////////////////////////////

    // lines in the run window get the test words, all others the fill
    task automatic load_lines(input int t);
        logic [31:0] base;
        logic [31:0] len;
        logic        in_run;
        base = pat[t*REC_WORDS + 2];
        len  = pat[t*REC_WORDS + 3];
        for (int l = 0; l < `CONV_LINE_DEPTH; l++) begin
            in_run = (l >= base) && (l < base + len);
            write_word(7'(l*2),     in_run ? pat[t*REC_WORDS+4] : pat[t*REC_WORDS+8]);
            write_word(7'(l*2 + 1), in_run ? pat[t*REC_WORDS+5] : pat[t*REC_WORDS+9]);
            write_word(7'(32 + l*2),     in_run ? pat[t*REC_WORDS+6] : pat[t*REC_WORDS+8]);
            write_word(7'(32 + l*2 + 1), in_run ? pat[t*REC_WORDS+7] : pat[t*REC_WORDS+9]);
        end
    endtask

    task automatic run_test(input int t);
        logic [31:0] kind;
        logic [31:0] base;
        logic [31:0] len;
        logic [31:0] rd;
        kind      = pat[t*REC_WORDS + 1];
        base      = pat[t*REC_WORDS + 2];
        len       = pat[t*REC_WORDS + 3];
        test_idx  = t;
        timed_out = 1'b0;
        if (kind == 1 || kind == 2) begin
            load_lines(t);
        end
        if (kind != 0) begin
            write_ctrl(base, len);
        end
        if (kind == 2) begin
            // these writes must stall until the run ends
            write_word(7'(base*2),     pat[t*REC_WORDS + 10]);
            write_word(7'(base*2 + 1), pat[t*REC_WORDS + 10]);
            // a stalled write lands only once the run is over
            final_status = 1'b1;
            read_word(`CONV_REG_STATUS, rd);
            final_status = 1'b0;
        end
        if (kind == 1 || kind == 2 || kind == 4) begin
            wait_done();
        end
        final_status = 1'b1;
        read_word(`CONV_REG_STATUS, rd);
        final_status = 1'b0;
        read_word(`CONV_REG_RESULT, rd);
        test_end = 1'b1;
        @(posedge clk_i);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        clk_i         = 1'b0;
        rd_weight_rst = 1'b1;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        test_idx      = 0;
        final_status  = 1'b0;
        test_end      = 1'b0;
        timed_out     = 1'b0;
        timeouts      = 0;
        cycle_count   = 0;
        $readmemh("dv/conv_patterns.dat", pat);
        repeat (8) @(posedge clk_i);
        #1;
        rd_weight_rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        @(posedge clk_i);
        $display("summary: %0d tests passed, %0d tests failed, %0d mismatches, %0d timeouts",
                 pass_count, fail_count, mismatch_count, timeouts);
        if (fail_count == 0 && mismatch_count == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+common
common/conv_pkg.sv
hw/line_ram.sv
hw/wb_conv_regs.sv
conv_engine/op_counter.sv
conv_engine/conv_ctrl_fsm.sv
conv_engine/dot_product.sv
hw/conv_engine_top.sv
dv/conv_props.sv
dv/conv_checker.sv
dv/tb_conv_top.sv

// File: Makefile
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_conv_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/conv_patterns.dat
// record: id kind base length feat_lo feat_hi
//         wgt_lo wgt_hi fill_lo fill_hi busy_word expected
// kind 0 reset check, 1 load and run, 2 write while busy, 3 ctrl only, 4 rerun
00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000
// single line, lanes 1..8 against alternating weights
00000001 00000001 00000000 00000001 04030201 08070605
FE02FF01 FC04FD03 7F7F7F7F 7F7F7F7F 00000000 FFFFFFF6
// lines 5..10 out of a fully loaded memory
00000002 00000001 00000005 00000006 02020202 02020202
03030303 03030303 7F7F7F7F 7F7F7F7F 00000000 00000120
// -128 times -128 over all 16 lines
00000003 00000001 00000000 00000010 80808080 80808080
80808080 80808080 00000000 00000000 00000000 00200000
// mixed sign gives a negative sum
00000004 00000001 00000002 00000003 7F7F7F7F 7F7F7F7F
81818181 81818181 7F7F7F7F 7F7F7F7F 00000000 FFFA17E8
// feature line 1 rewritten during the run
00000005 00000002 00000001 00000004 01010101 01010101
01010101 01010101 7F7F7F7F 7F7F7F7F 02020202 00000020
// same window again sees the new line
00000006 00000004 00000001 00000004 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000028
// zero length keeps the previous result
00000007 00000003 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000028
